// ==== common/rx_intf_params.svh ====
// rx_intf parameters
// widths and counts shared by the sample path and the packet block
`ifndef RX_INTF_PARAMS_SVH
`define RX_INTF_PARAMS_SVH

// one I or Q component
`define IQ_WIDTH 16

// antennas carried in one ADC word
`define NUM_ANT 2

// ADC word and packet word
`define WORD_WIDTH 64

// left shift amount of the baseband gain
`define GAIN_WIDTH 3

// packet byte count and sequence number
`define BYTE_COUNT_WIDTH 16
`define SN_WIDTH 16

`endif

// ==== common/rx_sample_pkg.sv ====
// rx sample types
// I/Q sample layout and the two views of the ADC word
`include "rx_intf_params.svh"

package rx_sample_pkg;

    // q in the upper half, i in the lower half
    typedef struct packed {
        logic [`IQ_WIDTH-1:0] q;
        logic [`IQ_WIDTH-1:0] i;
    } iq_sample_t;

    // antenna 0 sits in the low 32 bits
    typedef union packed {
        logic [`WORD_WIDTH-1:0] raw;
        iq_sample_t [`NUM_ANT-1:0] ant;
    } adc_word_u;

    // number of bits to shift left
    typedef logic [`GAIN_WIDTH-1:0] gain_t;

endpackage

// ==== common/rx_pkt_pkg.sv ====
// rx packet types
// output word, byte count, sequence number and trailer layout
`include "rx_intf_params.svh"

package rx_pkt_pkg;

    typedef logic [`WORD_WIDTH-1:0] pkt_word_t;

    typedef logic [`BYTE_COUNT_WIDTH-1:0] byte_count_t;

    typedef logic [`SN_WIDTH-1:0] pkt_sn_t;

    // last word of every packet
    typedef struct packed {
        logic [14:0] rsvd_hi;
        logic fcs_ok;
        pkt_sn_t sn;
        logic [15:0] rsvd_lo;
        byte_count_t byte_count;
    } trailer_t;

endpackage

// ==== logic/ant_router.sv ====
// antenna router
// swap, mute or tx loopback selection in front of the gain stages
`timescale 1ns/1ns
`include "rx_intf_params.svh"

module ant_router
    import rx_sample_pkg::*;
(
    input  adc_word_u adc_data,
    input  logic adc_valid,
    input  iq_sample_t iq0_from_tx_intf,
    input  iq_sample_t iq1_from_tx_intf,
    input  logic iq_valid_from_tx_intf,
    input  logic ant_swap,
    input  logic mute_ant0,
    input  logic loopback_en,
    output iq_sample_t [`NUM_ANT-1:0] ant_sample,
    output logic ant_valid
);

    iq_sample_t [`NUM_ANT-1:0] swapped;
    iq_sample_t [`NUM_ANT-1:0] muted;

    // reverse the antenna order when asked
    always_comb
    begin
        for (int a = 0; a < `NUM_ANT; a++)
        begin
            if (ant_swap)
                swapped[a] = adc_data.ant[`NUM_ANT-1-a];
            else
                swapped[a] = adc_data.ant[a];
        end
    end

    // mute applies after the swap, slot 0 only
    always_comb
    begin
        muted = swapped;
        if (mute_ant0)
            muted[0] = '0;
    end

    always_comb
    begin
        if (loopback_en)
        begin
            ant_sample[0] = iq0_from_tx_intf;
            ant_sample[1] = iq1_from_tx_intf;
            ant_valid = iq_valid_from_tx_intf;
        end
        else
        begin
            ant_sample = muted;
            ant_valid = adc_valid;
        end
    end

endmodule

// ==== logic/ant_gain_stage.sv ====
// antenna gain stage
// left shift of both components and one register stage
`timescale 1ns/1ns
`include "rx_intf_params.svh"

module ant_gain_stage
    import rx_sample_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  iq_sample_t sample_in,
    input  logic valid_in,
    input  gain_t bb_gain,
    output iq_sample_t sample_out,
    output logic valid_out
);

    // shifted result keeps IQ_WIDTH bits, overflow wraps
    always_ff @(posedge clk)
    begin
        if (valid_in)
        begin
            sample_out.i <= sample_in.i << bb_gain;
            sample_out.q <= sample_in.q << bb_gain;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

endmodule

// ==== logic/sample_merge.sv ====
// sample merge
// joins the antenna samples into the i-upper output words
`timescale 1ns/1ns
`include "rx_intf_params.svh"

module sample_merge
    import rx_sample_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  iq_sample_t [`NUM_ANT-1:0] ant_sample,
    input  logic [`NUM_ANT-1:0] ant_valid,
    input  logic sample_out_en,
    output logic [2*`IQ_WIDTH-1:0] sample0,
    output logic [2*`IQ_WIDTH-1:0] sample1,
    output logic sample_strobe
);

    logic out_en_q;
    logic all_valid;

    assign all_valid = &ant_valid;

    // enable lined up with the router input cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_en_q <= 1'b0;
            sample_strobe <= 1'b0;
        end
        else
        begin
            out_en_q <= sample_out_en;
            sample_strobe <= all_valid & out_en_q;
        end
    end

    // i goes to the upper half on the output side
    always_ff @(posedge clk)
    begin
        if (all_valid)
        begin
            sample0 <= {ant_sample[0].i, ant_sample[0].q};
            sample1 <= {ant_sample[1].i, ant_sample[1].q};
        end
    end

endmodule

// ==== rx_pkt/byte_packer.sv ====
// byte packer
// packs rx bytes into words, flushes, appends the fcs/sn trailer, raises the interrupt
`timescale 1ns/1ns
`include "rx_intf_params.svh"

module byte_packer
    import rx_pkt_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic pkt_header_valid_strobe,
    input  logic [7:0] byte_in,
    input  logic byte_in_strobe,
    input  logic fcs_in_strobe,
    input  logic fcs_ok,
    input  logic intr_on_any_fcs,
    output pkt_word_t word_out,
    output logic word_out_strobe,
    output logic rx_pkt_intr
);

    localparam int BYTES_PER_WORD = `WORD_WIDTH / 8;
    localparam int POS_WIDTH = $clog2(BYTES_PER_WORD);

    logic [POS_WIDTH-1:0] byte_pos;
    byte_count_t byte_count;
    pkt_sn_t sn;
    pkt_word_t word_buf;
    logic fcs_ok_q;
    logic trailer_pending;
    logic take_byte;
    logic word_done;
    logic flush;
    logic [6:0] pad_bits;
    trailer_t trailer;

    assign take_byte = byte_in_strobe & ~pkt_header_valid_strobe;
    assign word_done = take_byte && (byte_pos == POS_WIDTH'(BYTES_PER_WORD - 1));
    assign flush = fcs_in_strobe & ~pkt_header_valid_strobe & ~byte_in_strobe &
                   (byte_pos != '0);

    // bytes enter at the top, so a partial word must move down to lane 0
    assign pad_bits = {4'd8 - {1'b0, byte_pos}, 3'b000};

    always_comb
    begin
        trailer = '0;
        trailer.fcs_ok = fcs_ok_q;
        trailer.sn = sn;
        trailer.byte_count = byte_count;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_pos <= '0;
            byte_count <= '0;
            sn <= '0;
            trailer_pending <= 1'b0;
            word_out_strobe <= 1'b0;
            rx_pkt_intr <= 1'b0;
        end
        else
        begin
            word_out_strobe <= word_done | flush | trailer_pending;
            rx_pkt_intr <= 1'b0;
            trailer_pending <= fcs_in_strobe;
            if (pkt_header_valid_strobe)
            begin
                byte_pos <= '0;
                byte_count <= '0;
            end
            else if (byte_in_strobe)
            begin
                byte_pos <= byte_pos + 1'b1;
                byte_count <= byte_count + 1'b1;
            end
            else if (fcs_in_strobe)
                byte_pos <= '0;
            // trailer cycle
            if (trailer_pending)
            begin
                rx_pkt_intr <= fcs_ok_q | intr_on_any_fcs;
                sn <= sn + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_byte)
            word_buf <= {byte_in, word_buf[`WORD_WIDTH-1:8]};
        if (fcs_in_strobe)
            fcs_ok_q <= fcs_ok;
        if (word_done)
            word_out <= {byte_in, word_buf[`WORD_WIDTH-1:8]};
        else if (flush)
            word_out <= word_buf >> pad_bits;
        else if (trailer_pending)
            word_out <= trailer;
    end

endmodule

// ==== logic/rx_intf.sv ====
// rx_intf top
// two-antenna sample path plus rx packet packing with trailer and interrupt
`timescale 1ns/1ns
`include "rx_intf_params.svh"

module rx_intf
    import rx_sample_pkg::*;
    import rx_pkt_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  adc_word_u adc_data,
    input  logic adc_valid,
    input  iq_sample_t iq0_from_tx_intf,
    input  iq_sample_t iq1_from_tx_intf,
    input  logic iq_valid_from_tx_intf,
    input  logic ant_swap,
    input  logic mute_ant0,
    input  logic loopback_en,
    input  gain_t bb_gain,
    input  logic sample_out_en,
    input  logic intr_on_any_fcs,
    input  logic pkt_header_valid_strobe,
    input  logic [7:0] byte_in,
    input  logic byte_in_strobe,
    input  logic fcs_in_strobe,
    input  logic fcs_ok,
    output logic [2*`IQ_WIDTH-1:0] sample0,
    output logic [2*`IQ_WIDTH-1:0] sample1,
    output logic sample_strobe,
    output pkt_word_t word_out,
    output logic word_out_strobe,
    output logic rx_pkt_intr
);

    iq_sample_t [`NUM_ANT-1:0] router_sample;
    logic router_valid;
    iq_sample_t [`NUM_ANT-1:0] gain_sample;
    logic [`NUM_ANT-1:0] gain_valid;

    ant_router ant_router_i (
        .adc_data(adc_data),
        .adc_valid(adc_valid),
        .iq0_from_tx_intf(iq0_from_tx_intf),
        .iq1_from_tx_intf(iq1_from_tx_intf),
        .iq_valid_from_tx_intf(iq_valid_from_tx_intf),
        .ant_swap(ant_swap),
        .mute_ant0(mute_ant0),
        .loopback_en(loopback_en),
        .ant_sample(router_sample),
        .ant_valid(router_valid)
    );

    // one gain stage per antenna
    for (genvar g = 0; g < `NUM_ANT; g++)
    begin : gen_gain
        ant_gain_stage ant_gain_stage_i (
            .clk(clk),
            .reset(reset),
            .sample_in(router_sample[g]),
            .valid_in(router_valid),
            .bb_gain(bb_gain),
            .sample_out(gain_sample[g]),
            .valid_out(gain_valid[g])
        );
    end

    sample_merge sample_merge_i (
        .clk(clk),
        .reset(reset),
        .ant_sample(gain_sample),
        .ant_valid(gain_valid),
        .sample_out_en(sample_out_en),
        .sample0(sample0),
        .sample1(sample1),
        .sample_strobe(sample_strobe)
    );

    byte_packer byte_packer_i (
        .clk(clk),
        .reset(reset),
        .pkt_header_valid_strobe(pkt_header_valid_strobe),
        .byte_in(byte_in),
        .byte_in_strobe(byte_in_strobe),
        .fcs_in_strobe(fcs_in_strobe),
        .fcs_ok(fcs_ok),
        .intr_on_any_fcs(intr_on_any_fcs),
        .word_out(word_out),
        .word_out_strobe(word_out_strobe),
        .rx_pkt_intr(rx_pkt_intr)
    );

endmodule

// ==== verification/rx_intf_sva.sv ====
// rx_intf assertions
// reset state, interrupt and trailer timing at the top level
`timescale 1ns/1ns

module rx_intf_sva (
    input logic clk,
    input logic reset,
    input logic fcs_in_strobe,
    input logic sample_strobe,
    input logic word_out_strobe,
    input logic rx_pkt_intr
);

    // strobes come out of reset low
    reset_outputs_low: assert property (@(posedge clk)
        reset |=> !sample_strobe && !word_out_strobe && !rx_pkt_intr)
        else $error("outputs not low after a reset cycle");

    intr_with_word: assert property (@(posedge clk) disable iff (reset)
        rx_pkt_intr |-> word_out_strobe)
        else $error("rx_pkt_intr without word_out_strobe");

    // trailer lands two cycles after the fcs strobe
    trailer_after_fcs: assert property (@(posedge clk) disable iff (reset)
        fcs_in_strobe |-> ##2 word_out_strobe)
        else $error("no trailer word two cycles after fcs_in_strobe");

    intr_after_fcs: assert property (@(posedge clk) disable iff (reset)
        rx_pkt_intr |-> $past(fcs_in_strobe, 2))
        else $error("rx_pkt_intr not in the trailer cycle");

endmodule

bind rx_intf rx_intf_sva rx_intf_sva_i (
    .clk(clk),
    .reset(reset),
    .fcs_in_strobe(fcs_in_strobe),
    .sample_strobe(sample_strobe),
    .word_out_strobe(word_out_strobe),
    .rx_pkt_intr(rx_pkt_intr)
);

// ==== verification/rx_intf_tb.sv ====
// rx_intf testbench
// random sample path and packet traffic checked against reference models
`timescale 1ns/1ns
`include "rx_intf_params.svh"

module rx_intf_tb;

    localparam int CLK_PERIOD = 4;
    localparam int N_SAMPLES = 400;
    localparam int N_PKTS = 60;
    // bytes come with random gaps, so allow plenty per packet
    localparam int MAX_CYCLES = N_SAMPLES * 2 + N_PKTS * 120 + 200;

    logic clk;
    logic reset;
    logic [`WORD_WIDTH-1:0] adc_data;
    logic adc_valid;
    logic [2*`IQ_WIDTH-1:0] iq0_from_tx_intf;
    logic [2*`IQ_WIDTH-1:0] iq1_from_tx_intf;
    logic iq_valid_from_tx_intf;
    logic ant_swap;
    logic mute_ant0;
    logic loopback_en;
    logic [`GAIN_WIDTH-1:0] bb_gain;
    logic sample_out_en;
    logic intr_on_any_fcs;
    logic pkt_header_valid_strobe;
    logic [7:0] byte_in;
    logic byte_in_strobe;
    logic fcs_in_strobe;
    logic fcs_ok;
    logic [2*`IQ_WIDTH-1:0] sample0;
    logic [2*`IQ_WIDTH-1:0] sample1;
    logic sample_strobe;
    logic [`WORD_WIDTH-1:0] word_out;
    logic word_out_strobe;
    logic rx_pkt_intr;

    int cyc = 0;
    int sample_errors = 0;
    int packet_errors = 0;
    logic [31:0] rng = 32'd10;
    logic [15:0] pkt_sn = '0;
    string test_name = "reset";

    logic [63:0] exp_sample_q[$];
    int exp_due_q[$];
    logic [63:0] exp_word_q[$];
    logic exp_intr_q[$];
    logic [7:0] pkt_bytes[40];

    rx_intf uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // expected {sample1, sample0} with each output as {i, q} after the shift
    function automatic logic [63:0] sample_ref(input logic [63:0] adc, input logic [31:0] tx0,
            input logic [31:0] tx1, input logic swap, input logic mute, input logic loop,
            input logic [2:0] gain);
        logic [31:0] a0;
        logic [31:0] a1;
        logic [15:0] i0;
        logic [15:0] q0;
        logic [15:0] i1;
        logic [15:0] q1;
        if (loop)
        begin
            a0 = tx0;
            a1 = tx1;
        end
        else
        begin
            a0 = swap ? adc[63:32] : adc[31:0];
            a1 = swap ? adc[31:0] : adc[63:32];
            if (mute)
                a0 = '0;
        end
        i0 = a0[15:0] << gain;
        q0 = a0[31:16] << gain;
        i1 = a1[15:0] << gain;
        q1 = a1[31:16] << gain;
        return {i1, q1, i0, q0};
    endfunction

    // expected words of one packet, first byte lowest, then the trailer
    function automatic void pkt_ref(input int len, input logic ok, input logic any_fcs,
            input logic [15:0] seq);
        logic [63:0] w;
        w = '0;
        for (int n = 0; n < len; n++)
        begin
            w[8*(n%8) +: 8] = pkt_bytes[n];
            if (n % 8 == 7 || n == len - 1)
            begin
                exp_word_q.push_back(w);
                exp_intr_q.push_back(1'b0);
                w = '0;
            end
        end
        exp_word_q.push_back({15'd0, ok, seq, 16'd0, 16'(len)});
        exp_intr_q.push_back(ok | any_fcs);
    endfunction

    // sample path compare
    always @(negedge clk)
    begin
        if (!reset && sample_strobe)
        begin
            assert (exp_sample_q.size() > 0)
            else
            begin
                sample_errors++;
                $display("%s: sample_strobe with no sample expected, cycle %0d", test_name, cyc);
            end
            if (exp_sample_q.size() > 0)
            begin
                assert (exp_due_q[0] == cyc)
                else
                begin
                    sample_errors++;
                    $display("%s: sample came at cycle %0d instead of cycle %0d",
                             test_name, cyc, exp_due_q[0]);
                end
                assert ({sample1, sample0} == exp_sample_q[0])
                else
                begin
                    sample_errors++;
                    $display("error %s: expected %h, actual %h",
                             test_name, exp_sample_q[0], {sample1, sample0});
                end
                void'(exp_sample_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
    end

    // packet compare
    always @(negedge clk)
    begin
        if (!reset)
        begin
            assert (!rx_pkt_intr || word_out_strobe)
            else
            begin
                packet_errors++;
                $display("%s: rx_pkt_intr pulsed without a word", test_name);
            end
            if (word_out_strobe)
            begin
                assert (exp_word_q.size() > 0)
                else
                begin
                    packet_errors++;
                    $display("%s: word_out_strobe with no word expected", test_name);
                end
                if (exp_word_q.size() > 0)
                begin
                    assert (word_out == exp_word_q[0])
                    else
                    begin
                        packet_errors++;
                        $display("error %s: expected %h, actual %h",
                                 test_name, exp_word_q[0], word_out);
                    end
                    assert (rx_pkt_intr == exp_intr_q[0])
                    else
                    begin
                        packet_errors++;
                        $display("error %s intr: expected %b, actual %b",
                                 test_name, exp_intr_q[0], rx_pkt_intr);
                    end
                    void'(exp_word_q.pop_front());
                    void'(exp_intr_q.pop_front());
                end
            end
        end
    end

    // en_mode 0 keeps the output enabled, 1 disabled, 2 random
    task automatic drive_samples(input int count, input logic loop, input int en_mode);
        logic [31:0] r;
        logic valid;
        logic en;
        for (int n = 0; n < count; n++)
        begin
            @(posedge clk);
            #1;
            r = next_rand();
            valid = (r[1:0] != 2'b00);
            if (en_mode == 0)
                en = 1'b1;
            else if (en_mode == 1)
                en = 1'b0;
            else
                en = r[7];
            adc_data = {next_rand(), next_rand()};
            iq0_from_tx_intf = next_rand();
            iq1_from_tx_intf = next_rand();
            ant_swap = r[2];
            mute_ant0 = r[3];
            bb_gain = r[6:4];
            sample_out_en = en;
            loopback_en = loop;
            // the unused valid toggles too and must be ignored
            adc_valid = loop ? r[8] : valid;
            iq_valid_from_tx_intf = loop ? valid : r[8];
            if (valid && en)
            begin
                exp_sample_q.push_back(sample_ref(adc_data, iq0_from_tx_intf, iq1_from_tx_intf,
                                                  ant_swap, mute_ant0, loop, bb_gain));
                exp_due_q.push_back(cyc + 2);
            end
        end
        @(posedge clk);
        #1;
        adc_valid = 1'b0;
        iq_valid_from_tx_intf = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_sample_q.size() != 0 || exp_word_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic send_packet(input int len, input logic ok, input logic any_fcs);
        logic [31:0] r;
        int n;
        for (n = 0; n < len; n++)
        begin
            r = next_rand();
            pkt_bytes[n] = r[7:0];
        end
        pkt_ref(len, ok, any_fcs, pkt_sn);
        pkt_sn++;
        @(posedge clk);
        #1;
        intr_on_any_fcs = any_fcs;
        pkt_header_valid_strobe = 1'b1;
        n = 0;
        while (n < len)
        begin
            @(posedge clk);
            #1;
            pkt_header_valid_strobe = 1'b0;
            r = next_rand();
            byte_in_strobe = (r[1:0] != 2'b00);
            byte_in = byte_in_strobe ? pkt_bytes[n] : r[15:8];
            if (byte_in_strobe)
                n++;
        end
        @(posedge clk);
        #1;
        byte_in_strobe = 1'b0;
        fcs_in_strobe = 1'b1;
        fcs_ok = ok;
        @(posedge clk);
        #1;
        fcs_in_strobe = 1'b0;
        wait_drained();
    endtask

    initial
    begin
        int len;
        logic [31:0] r;
        reset = 1'b1;
        adc_data = '0;
        adc_valid = 1'b0;
        iq0_from_tx_intf = '0;
        iq1_from_tx_intf = '0;
        iq_valid_from_tx_intf = 1'b0;
        ant_swap = 1'b0;
        mute_ant0 = 1'b0;
        loopback_en = 1'b0;
        bb_gain = '0;
        sample_out_en = 1'b0;
        intr_on_any_fcs = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        byte_in = '0;
        byte_in_strobe = 1'b0;
        fcs_in_strobe = 1'b0;
        fcs_ok = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "adc_random";
        drive_samples(200, 1'b0, 0);
        wait_drained();
        test_name = "loopback";
        drive_samples(60, 1'b1, 0);
        wait_drained();
        test_name = "output_enable";
        drive_samples(60, 1'b0, 1);
        drive_samples(80, 1'b0, 2);
        wait_drained();

        // good packets first, then random fcs and interrupt mode
        test_name = "packing";
        for (int p = 0; p < N_PKTS / 2; p++)
        begin
            r = next_rand();
            len = int'(r % 40) + 1;
            send_packet(len, 1'b1, 1'b0);
        end
        test_name = "fcs_intr";
        for (int p = 0; p < N_PKTS / 2; p++)
        begin
            r = next_rand();
            len = int'(r[15:0] % 40) + 1;
            send_packet(len, r[16], r[17]);
        end

        $display("errors: sample path %0d, packet path %0d", sample_errors, packet_errors);
        if (sample_errors + packet_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== rx_intf.f ====
+incdir+common
common/rx_sample_pkg.sv
common/rx_pkt_pkg.sv
logic/ant_router.sv
logic/ant_gain_stage.sv
logic/sample_merge.sv
rx_pkt/byte_packer.sv
logic/rx_intf.sv
verification/rx_intf_sva.sv
verification/rx_intf_tb.sv

// ==== Makefile ====
TOP = rx_intf_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f rx_intf.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f rx_intf.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log
